// File: compile.f
+incdir+verif
src/rename_pkg.sv
src/rename_request_port.sv
src/phys_free_list.sv
src/inflight_list.sv
src/rename_map_table.sv
src/renamer.sv
src/rename_result_port.sv
src/rename_top.sv
verif/rename_tb.sv

// File: Makefile
# Verilator build and run for the register rename unit testbench
TOP := rename_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ps -f compile.f \
		--top-module $(TOP) -o $(TOP)

# Pass only when the simulation prints the pass line
run: compile
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf obj_dir

// File: verif/rename_model.svh
//////////////////////////////
// Reference model of the rename unit
// Map table, free list and in-flight list
// Expected result for one operation
//////////////////////////////
`ifndef RENAME_MODEL_SVH
`define RENAME_MODEL_SVH

// One renaming as the model keeps it
typedef struct packed {
    arch_addr_t rd;
    phys_addr_t new_phys;
    phys_addr_t prev_phys;
} model_rec_t;

phys_addr_t model_map [NUM_ARCH_REGS];
phys_addr_t model_free [$];
model_rec_t model_inflight [$];

// State right after the init walk
function automatic void model_reset();
    model_free.delete();
    model_inflight.delete();
    for (int i = 0; i < NUM_ARCH_REGS; i++) begin
        model_map[i] = phys_addr_t'(i);
    end
    // Upper half free, in ascending order
    for (int i = NUM_ARCH_REGS; i < NUM_PHYS_REGS; i++) begin
        model_free.push_back(phys_addr_t'(i));
    end
endfunction

// Apply one operation and return what the unit should answer
function automatic rename_result_t predict_result(input rename_op_t op);
    rename_result_t res;
    model_rec_t     rec;
    rename_fields_t f;
    logic           discard;
    res     = '0;
    rec     = '0;
    f       = op.payload.ren;
    discard = op.payload.ret.discard;
    res.kind = op.kind;
    if (op.kind == RENAME) begin
        if (model_inflight.size() >= INFLIGHT_DEPTH) begin
            res.status = LIST_FULL;
        end else begin
            // Sources see the mapping before this write
            res.phys_rs1  = model_map[f.rs1];
            res.phys_rs2  = model_map[f.rs2];
            rec.rd        = f.rd;
            rec.prev_phys = model_map[f.rd];
            // x0 stays on physical 0
            if (f.rd != '0) begin
                rec.new_phys    = model_free.pop_front();
                model_map[f.rd] = rec.new_phys;
            end
            model_inflight.push_back(rec);
            res.phys_rd = rec.new_phys;
        end
    end else if (model_inflight.size() == 0) begin
        res.status = LIST_EMPTY;
    end else begin
        rec = model_inflight.pop_front();
        if (discard) begin
            res.restored_rd = rec.rd;
        end
        if (rec.rd != '0) begin
            // Squash frees the new register, commit the old one
            res.freed_phys = discard ? rec.new_phys : rec.prev_phys;
            model_free.push_back(res.freed_phys);
            if (discard) begin
                model_map[rec.rd] = rec.prev_phys;
            end
        end
    end
    return res;
endfunction

`endif

// File: verif/rename_tb.sv
`timescale 1ns/1ps
//////////////////////////////
// Testbench for the rename unit
// Clock, reset and handshake drivers
// Directed and random operations
// Result compare, timeout and counts
//////////////////////////////
module rename_tb;

    import rename_pkg::*;

    localparam int INFLIGHT_DEPTH = 32;
    localparam int DIRECTED_OPS   = 74;
    localparam int NUM_RANDOM     = 150;
    localparam int NUM_OPS        = DIRECTED_OPS + NUM_RANDOM;
    localparam int TIMEOUT_CYCLES = 40 * NUM_OPS + 200;

    `include "rename_model.svh"

    logic           clk;
    logic           arst_n;
    logic           in_req;
    rename_op_t     in_op;
    logic           in_ack;
    logic           out_req;
    rename_result_t out_res;
    logic           out_ack;

    integer         seed;
    int             errors;
    int             checks;
    int             op_count;
    int             result_count;
    int             cycle_count;
    // Cycles before out_ack rises and before it falls
    int             ack_delay;
    rename_result_t last_res;
    rename_result_t expected_q [$];

    rename_top #(
        .INFLIGHT_DEPTH (INFLIGHT_DEPTH)
    ) UUT (
        .clk     (clk),
        .arst_n  (arst_n),
        .in_req  (in_req),
        .in_op   (in_op),
        .in_ack  (in_ack),
        .out_req (out_req),
        .out_res (out_res),
        .out_ack (out_ack)
    );

    // 100 ns clock
    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    //////////////////////////////
    // Operation builders and helpers
    //////////////////////////////
    function automatic rename_op_t rename_op(input arch_addr_t rd, input arch_addr_t rs1,
                                             input arch_addr_t rs2);
        rename_op_t op;
        op                 = '0;
        op.kind            = RENAME;
        op.payload.ren.rd  = rd;
        op.payload.ren.rs1 = rs1;
        op.payload.ren.rs2 = rs2;
        return op;
    endfunction

    function automatic rename_op_t retire_op(input logic discard);
        rename_op_t op;
        op                     = '0;
        op.kind                = RETIRE;
        op.payload.ret.discard = discard;
        return op;
    endfunction

    task automatic expect_field(input string name, input int got, input int want);
        checks++;
        if (got != want) begin
            $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, want);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            $display("test %s: pass", name);
        end else begin
            $display("test %s: fail, %0d errors", name, errors - errors_before);
        end
    endtask

    // Full four-phase cycle on the input side, called on a falling edge
    task automatic send_op(input rename_op_t op, input int req_hold, input int ack_hold);
        expected_q.push_back(predict_result(op));
        op_count++;
        ack_delay = ack_hold;
        in_op     = op;
        in_req    = 1'b1;
        @(negedge clk);
        while (!in_ack) begin
            @(negedge clk);
        end
        // Late drop of the request
        repeat (req_hold) @(negedge clk);
        in_req = 1'b0;
        @(negedge clk);
        while (in_ack) begin
            @(negedge clk);
        end
    endtask

    //////////////////////////////
    // Result side and compare
    //////////////////////////////
    initial begin : compare_results
        rename_result_t want;
        out_ack = 1'b0;
        forever begin
            @(negedge clk);
            if (out_req) begin
                checks++;
                result_count++;
                if (expected_q.size() == 0) begin
                    $display("Result at %0t arrived with no operation pending", $time);
                    errors++;
                end else begin
                    want = expected_q.pop_front();
                    if (out_res !== want) begin
                        $display("[ERROR] %0t out_res got %h expected %h", $time,
                                 out_res, want);
                        errors++;
                    end
                end
                last_res = out_res;
                repeat (ack_delay) @(negedge clk);
                out_ack = 1'b1;
                while (out_req) begin
                    @(negedge clk);
                end
                // Late release of the ack
                repeat (ack_delay) @(negedge clk);
                out_ack = 1'b0;
            end
        end
    end

    // Watchdog
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Run stopped after %0d cycles without finishing", cycle_count);
        $display("TEST FAILED");
        $finish;
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////
    initial begin : stimulus
        logic [31:0] r;
        rename_op_t  op;
        int          start;
        seed         = 33559;
        errors       = 0;
        checks       = 0;
        op_count     = 0;
        result_count = 0;
        ack_delay    = 0;
        arst_n       = 1'b0;
        in_req       = 1'b0;
        in_op        = '0;
        model_reset();
        repeat (3) @(negedge clk);
        arst_n = 1'b1;

        // Identity sources, free registers from 32 up
        start = errors;
        send_op(rename_op(5'd1, 5'd2, 5'd3), 0, 0);
        expect_field("out_res.phys_rd", int'(last_res.phys_rd), 32);
        expect_field("out_res.phys_rs1", int'(last_res.phys_rs1), 2);
        expect_field("out_res.phys_rs2", int'(last_res.phys_rs2), 3);
        send_op(rename_op(5'd4, 5'd1, 5'd5), 0, 0);
        expect_field("out_res.phys_rd", int'(last_res.phys_rd), 33);
        expect_field("out_res.phys_rs1", int'(last_res.phys_rs1), 32);
        report_test("1 identity and first renames", start);

        // x0 takes no register
        start = errors;
        send_op(rename_op(5'd0, 5'd0, 5'd1), 0, 0);
        expect_field("out_res.phys_rd", int'(last_res.phys_rd), 0);
        expect_field("out_res.phys_rs2", int'(last_res.phys_rs2), 32);
        send_op(rename_op(5'd6, 5'd0, 5'd4), 0, 0);
        expect_field("out_res.phys_rs1", int'(last_res.phys_rs1), 0);
        expect_field("out_res.phys_rd", int'(last_res.phys_rd), 34);
        report_test("2 register zero", start);

        // Commits free x1 then x4 old registers, x0 record frees nothing
        start = errors;
        send_op(retire_op(1'b0), 0, 0);
        expect_field("out_res.freed_phys", int'(last_res.freed_phys), 1);
        send_op(retire_op(1'b0), 0, 0);
        expect_field("out_res.freed_phys", int'(last_res.freed_phys), 4);
        send_op(retire_op(1'b0), 0, 0);
        expect_field("out_res.freed_phys", int'(last_res.freed_phys), 0);
        // Use up 35..63, then physical 1 comes back
        for (int i = 0; i < 29; i++) begin
            send_op(rename_op(arch_addr_t'(7 + i % 20), arch_addr_t'(i),
                              arch_addr_t'(31 - i)), 0, 0);
        end
        send_op(rename_op(5'd27, 5'd1, 5'd4), 0, 0);
        expect_field("out_res.phys_rd", int'(last_res.phys_rd), 1);
        report_test("3 commit and reuse", start);

        // Oldest is x6 on 34
        start = errors;
        send_op(retire_op(1'b1), 0, 0);
        expect_field("out_res.freed_phys", int'(last_res.freed_phys), 34);
        expect_field("out_res.restored_rd", int'(last_res.restored_rd), 6);
        send_op(rename_op(5'd28, 5'd6, 5'd27), 0, 0);
        expect_field("out_res.phys_rs1", int'(last_res.phys_rs1), 6);
        expect_field("out_res.phys_rd", int'(last_res.phys_rd), 4);
        report_test("4 discard", start);

        // 32nd entry fills the list
        start = errors;
        send_op(rename_op(5'd29, 5'd0, 5'd0), 0, 0);
        expect_field("out_res.status", int'(last_res.status), int'(OK));
        send_op(rename_op(5'd30, 5'd0, 5'd0), 0, 0);
        expect_field("out_res.status", int'(last_res.status), int'(LIST_FULL));
        expect_field("out_res.phys_rd", int'(last_res.phys_rd), 0);
        for (int i = 0; i < INFLIGHT_DEPTH; i++) begin
            send_op(retire_op(1'b0), 0, 0);
        end
        send_op(retire_op(1'b0), 0, 0);
        expect_field("out_res.status", int'(last_res.status), int'(LIST_EMPTY));
        expect_field("out_res.freed_phys", int'(last_res.freed_phys), 0);
        report_test("5 full and empty", start);

        // Random mix with late req drop and late ack
        start = errors;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            r = $random(seed);
            if (r[3:0] < 4'd10) begin
                op = rename_op(r[8:4], r[13:9], r[18:14]);
            end else begin
                op = retire_op(r[19]);
            end
            send_op(op, int'(r[21:20]), int'(r[23:22]));
        end
        report_test("6 random with late handshakes", start);

        // Every operation answered exactly once
        if (expected_q.size() != 0 || result_count != op_count) begin
            $display("Result count mismatch: %0d operations sent, %0d results seen",
                     op_count, result_count);
            errors++;
        end
        $display("checks %0d, errors %0d, operations %0d", checks, errors, op_count);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: src/rename_top.sv
`timescale 1ns/1ps
//////////////////////////////
// Register rename unit top level
// Input port, renamer, output port
//////////////////////////////
module rename_top #(
    parameter int INFLIGHT_DEPTH = 32
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       in_req,
    input  rename_pkg::rename_op_t     in_op,
    output logic                       in_ack,
    output logic                       out_req,
    output rename_pkg::rename_result_t out_res,
    input  logic                       out_ack
);

    import rename_pkg::*;

    rename_op_t     op;
    rename_result_t res;
    logic           op_valid;
    logic           res_valid;
    logic           ready;
    logic           done;

    // Decode and retire operations in
    rename_request_port req_port (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_req   (in_req),
        .in_op    (in_op),
        .in_ack   (in_ack),
        .ready    (ready),
        .done     (done),
        .op_valid (op_valid),
        .op       (op)
    );

    renamer #(
        .INFLIGHT_DEPTH (INFLIGHT_DEPTH)
    ) rename_core (
        .clk       (clk),
        .arst_n    (arst_n),
        .op_valid  (op_valid),
        .op        (op),
        .ready     (ready),
        .res_valid (res_valid),
        .res       (res)
    );

    // Results out
    rename_result_port res_port (
        .clk       (clk),
        .arst_n    (arst_n),
        .res_valid (res_valid),
        .res       (res),
        .out_req   (out_req),
        .out_res   (out_res),
        .out_ack   (out_ack),
        .done      (done)
    );

endmodule

// File: src/rename_result_port.sv
`timescale 1ns/1ps
//////////////////////////////
// Output side of the rename unit
// Result register and four-phase master
//////////////////////////////
module rename_result_port (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       res_valid,
    input  rename_pkg::rename_result_t res,
    output logic                       out_req,
    output rename_pkg::rename_result_t out_res,
    input  logic                       out_ack,
    output logic                       done
);

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        ACKED
    } state_t;

    state_t state;

    assign out_req = (state == REQ);
    // High from ack seen until ack released
    assign done    = (state == ACKED);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: begin
                    if (res_valid) begin
                        state <= REQ;
                    end
                end
                REQ: begin
                    // Req drops on the edge ack is seen
                    if (out_ack) begin
                        state <= ACKED;
                    end
                end
                ACKED: begin
                    if (!out_ack) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Held stable through the handshake
    always_ff @(posedge clk) begin
        if (res_valid && (state == IDLE)) begin
            out_res <= res;
        end
    end

endmodule

// File: src/renamer.sv
`timescale 1ns/1ps
//////////////////////////////
// Rename processing block
// Operation decode and list control
// Map table update and result forming
//////////////////////////////
module renamer #(
    parameter int INFLIGHT_DEPTH = 32
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       op_valid,
    input  rename_pkg::rename_op_t     op,
    output logic                       ready,
    output logic                       res_valid,
    output rename_pkg::rename_result_t res
);

    import rename_pkg::*;

    // One renaming in program order
    typedef struct packed {
        arch_addr_t rd;
        phys_addr_t new_phys;
        phys_addr_t prev_phys;
    } inflight_rec_t;

    rename_fields_t ren;
    logic           discard;
    inflight_rec_t  push_rec;
    inflight_rec_t  pop_rec;
    logic           list_full;
    logic           list_empty;
    logic           rename_ok;
    logic           retire_ok;
    logic           rd_nz;
    logic           take_phys;
    logic           restore;
    logic           fl_push;
    phys_addr_t     fl_push_data;
    phys_addr_t     fl_head;
    logic [6:0]     fl_count;
    logic           init_busy;
    logic           map_wr_en;
    arch_addr_t     map_wr_addr;
    phys_addr_t     map_wr_data;
    phys_addr_t     phys_rs1;
    phys_addr_t     phys_rs2;
    phys_addr_t     phys_old_rd;
    phys_addr_t     freed;
    rename_result_t res_next;

    assign ready = !init_busy;

    //////////////////////////////
    // Decode
    //////////////////////////////
    assign ren       = op.payload.ren;
    assign discard   = op.payload.ret.discard;
    assign rename_ok = op_valid && (op.kind == RENAME) && !list_full;
    assign retire_ok = op_valid && (op.kind == RETIRE) && !list_empty;
    // x0 keeps physical 0
    assign rd_nz     = |ren.rd;
    assign take_phys = rename_ok && rd_nz;
    // Squashed renaming of a real register
    assign restore   = retire_ok && discard && (|pop_rec.rd);

    // Squash gives back the new register, commit the old one
    assign freed = (pop_rec.rd == '0) ? '0
                 : (discard ? pop_rec.new_phys : pop_rec.prev_phys);

    //////////////////////////////
    // Free list
    //////////////////////////////
    // Init fill walks 32..63 off the occupancy count
    assign fl_push      = init_busy | (retire_ok && (|pop_rec.rd));
    assign fl_push_data = init_busy ? {1'b1, fl_count[4:0]} : freed;

    phys_free_list free_list (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (fl_push),
        .push_data (fl_push_data),
        .pop       (take_phys),
        .head      (fl_head),
        .count     (fl_count)
    );

    //////////////////////////////
    // In-flight list
    //////////////////////////////
    // Zero record for x0 so retires stay in step
    assign push_rec.rd        = ren.rd;
    assign push_rec.new_phys  = rd_nz ? fl_head : '0;
    assign push_rec.prev_phys = phys_old_rd;

    inflight_list #(
        .INFLIGHT_DEPTH (INFLIGHT_DEPTH)
    ) inflight (
        .clk      (clk),
        .arst_n   (arst_n),
        .push     (rename_ok),
        .pop      (retire_ok),
        .push_rec (push_rec),
        .pop_rec  (pop_rec),
        .full     (list_full),
        .empty    (list_empty)
    );

    //////////////////////////////
    // Map table
    //////////////////////////////
    assign map_wr_en   = take_phys | restore;
    assign map_wr_addr = take_phys ? ren.rd : pop_rec.rd;
    assign map_wr_data = take_phys ? fl_head : pop_rec.prev_phys;

    rename_map_table map_table (
        .clk       (clk),
        .arst_n    (arst_n),
        .wr_en     (map_wr_en),
        .wr_addr   (map_wr_addr),
        .wr_data   (map_wr_data),
        .rd_addr_a (ren.rs1),
        .rd_addr_b (ren.rs2),
        .rd_addr_c (ren.rd),
        .rd_data_a (phys_rs1),
        .rd_data_b (phys_rs2),
        .rd_data_c (phys_old_rd),
        .init_busy (init_busy)
    );

    //////////////////////////////
    // Result
    //////////////////////////////
    always_comb begin
        res_next      = '0;
        res_next.kind = op.kind;
        if (op.kind == RENAME) begin
            if (list_full) begin
                res_next.status = LIST_FULL;
            end else begin
                res_next.phys_rd  = push_rec.new_phys;
                res_next.phys_rs1 = phys_rs1;
                res_next.phys_rs2 = phys_rs2;
            end
        end else if (list_empty) begin
            res_next.status = LIST_EMPTY;
        end else begin
            res_next.freed_phys  = freed;
            res_next.restored_rd = discard ? pop_rec.rd : '0;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= op_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (op_valid) begin
            res <= res_next;
        end
    end

endmodule

// File: src/rename_map_table.sv
`timescale 1ns/1ps
//////////////////////////////
// Speculative map table
// 32 entries, one write port, three reads
// Identity fill after reset
//////////////////////////////
module rename_map_table (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   wr_en,
    input  rename_pkg::arch_addr_t wr_addr,
    input  rename_pkg::phys_addr_t wr_data,
    input  rename_pkg::arch_addr_t rd_addr_a,
    input  rename_pkg::arch_addr_t rd_addr_b,
    input  rename_pkg::arch_addr_t rd_addr_c,
    output rename_pkg::phys_addr_t rd_data_a,
    output rename_pkg::phys_addr_t rd_data_b,
    output rename_pkg::phys_addr_t rd_data_c,
    output logic                   init_busy
);

    import rename_pkg::*;

    phys_addr_t map [NUM_ARCH_REGS];

    // Init walk state
    arch_addr_t init_idx;

    // Merged write port
    logic       wr_sel;
    arch_addr_t wr_addr_sel;
    phys_addr_t wr_data_sel;

    //////////////////////////////
    // Post-reset fill
    //////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            init_busy <= 1'b1;
            init_idx  <= '0;
        end else if (init_busy) begin
            init_idx <= init_idx + arch_addr_t'(1);
            // Last entry written on this edge
            if (init_idx == arch_addr_t'(NUM_ARCH_REGS - 1)) begin
                init_busy <= 1'b0;
            end
        end
    end

    // Init owns the port while it runs
    assign wr_sel      = init_busy | wr_en;
    assign wr_addr_sel = init_busy ? init_idx : wr_addr;
    // xN maps to physical N
    assign wr_data_sel = init_busy ? {1'b0, init_idx} : wr_data;

    //////////////////////////////
    // Storage
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (wr_sel) begin
            map[wr_addr_sel] <= wr_data_sel;
        end
    end

    // Combinational reads
    assign rd_data_a = map[rd_addr_a];
    assign rd_data_b = map[rd_addr_b];
    assign rd_data_c = map[rd_addr_c];

endmodule

// File: src/inflight_list.sv
`timescale 1ns/1ps
//////////////////////////////
// In-flight renaming list
// Program-order FIFO of rename records
// Oldest record shown at the output
//////////////////////////////
module inflight_list #(
    parameter int INFLIGHT_DEPTH = 32,
    // Record of rd, new phys and previous phys
    localparam int REC_W = $bits(rename_pkg::arch_addr_t)
                         + 2 * $bits(rename_pkg::phys_addr_t)
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             push,
    input  logic             pop,
    input  logic [REC_W-1:0] push_rec,
    output logic [REC_W-1:0] pop_rec,
    output logic             full,
    output logic             empty
);

    localparam int PTR_W = $clog2(INFLIGHT_DEPTH);

    logic [REC_W-1:0] records [INFLIGHT_DEPTH];
    // Extra top bit tells full from empty
    logic [PTR_W:0]   wr_ptr;
    logic [PTR_W:0]   rd_ptr;

    assign empty = (wr_ptr == rd_ptr);
    assign full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W])
                && (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);

    // Oldest entry
    assign pop_rec = records[rd_ptr[PTR_W-1:0]];

    always_ff @(posedge clk) begin
        if (push) begin
            records[wr_ptr[PTR_W-1:0]] <= push_rec;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + (PTR_W + 1)'(1);
            end
            if (pop) begin
                rd_ptr <= rd_ptr + (PTR_W + 1)'(1);
            end
        end
    end

endmodule

// File: src/phys_free_list.sv
`timescale 1ns/1ps
//////////////////////////////
// Free physical register list
// Circular buffer with head lookahead
// Occupancy count for the init fill
//////////////////////////////
module phys_free_list (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   push,
    input  rename_pkg::phys_addr_t push_data,
    input  logic                   pop,
    output rename_pkg::phys_addr_t head,
    output logic [6:0]             count
);

    import rename_pkg::*;

    localparam int PTR_W = $clog2(NUM_PHYS_REGS);

    phys_addr_t       entries [NUM_PHYS_REGS];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;

    // Next free register, valid before the pop
    assign head = entries[rd_ptr];

    // Storage
    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= push_data;
        end
    end

    //////////////////////////////
    // Pointers and count
    //////////////////////////////
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            // Full 64 entry ring, pointers wrap on their own
            if (push) begin
                wr_ptr <= wr_ptr + PTR_W'(1);
            end
            if (pop) begin
                rd_ptr <= rd_ptr + PTR_W'(1);
            end
            case ({push, pop})
                2'b10: begin
                    count <= count + 7'd1;
                end
                2'b01: begin
                    count <= count - 7'd1;
                end
                default: begin
                    count <= count;
                end
            endcase
        end
    end

endmodule

// File: src/rename_request_port.sv
`timescale 1ns/1ps
//////////////////////////////
// Input side of the rename unit
// Four-phase slave for operation words
// Holds ack until the result is taken
//////////////////////////////
module rename_request_port (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   in_req,
    input  rename_pkg::rename_op_t in_op,
    output logic                   in_ack,
    input  logic                   ready,
    input  logic                   done,
    output logic                   op_valid,
    output rename_pkg::rename_op_t op
);

    typedef enum logic [1:0] {
        IDLE,
        BUSY,
        ACKED
    } state_t;

    state_t state;
    logic   accept;

    // Take a new word only from idle, and not during init
    assign accept = (state == IDLE) && in_req && ready;

    // Ack straight from state
    assign in_ack = (state == ACKED);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= IDLE;
            op_valid <= 1'b0;
        end else begin
            // Single pulse per accepted word
            op_valid <= accept;
            case (state)
                IDLE: begin
                    if (accept) begin
                        state <= BUSY;
                    end
                end
                BUSY: begin
                    // Result taken downstream
                    if (done) begin
                        state <= ACKED;
                    end
                end
                ACKED: begin
                    // Both sides back at rest before the next word
                    if (!in_req && !done) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Operation latch
    always_ff @(posedge clk) begin
        if (accept) begin
            op <= in_op;
        end
    end

endmodule

// File: src/rename_pkg.sv
//////////////////////////////
// Rename unit package
// Register address types and counts
// Operation word with its two decodings
// Status codes and the result word
//////////////////////////////
package rename_pkg;

    // Register address widths
    typedef logic [4:0] arch_addr_t;
    typedef logic [5:0] phys_addr_t;

    localparam int NUM_ARCH_REGS = 32;
    localparam int NUM_PHYS_REGS = 64;

    //////////////////////////////
    // Operation word
    //////////////////////////////
    typedef enum logic {
        RENAME = 1'b0,
        RETIRE = 1'b1
    } op_kind_t;

    // Decode side view
    typedef struct packed {
        arch_addr_t rd;
        arch_addr_t rs1;
        arch_addr_t rs2;
    } rename_fields_t;

    // Retire side view, discard set when the instruction was squashed
    typedef struct packed {
        logic        discard;
        logic [13:0] pad;
    } retire_fields_t;

    // Same 15 bits, read by kind
    typedef union packed {
        rename_fields_t ren;
        retire_fields_t ret;
    } op_payload_u;

    typedef struct packed {
        op_kind_t    kind;
        op_payload_u payload;
    } rename_op_t;

    //////////////////////////////
    // Result word
    //////////////////////////////
    typedef enum logic [1:0] {
        OK         = 2'd0,
        LIST_FULL  = 2'd1,
        LIST_EMPTY = 2'd2
    } rename_status_t;

    typedef struct packed {
        op_kind_t       kind;
        rename_status_t status;
        phys_addr_t     phys_rd;
        phys_addr_t     phys_rs1;
        phys_addr_t     phys_rs2;
        phys_addr_t     freed_phys;
        arch_addr_t     restored_rd;
    } rename_result_t;

endpackage
